// File: design/dispatch_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_issue_cfg.svh"

module dispatch_ctrl (
    input  logic                           head_valid_i,
    input  tomasulo_issue_pkg::ctl_word_t  head_i,
    input  tomasulo_issue_pkg::rs_status_t status_i,
    output logic                           yumi_o,
    output tomasulo_issue_pkg::dispatch_t  dispatch_o,
    output tomasulo_issue_pkg::ctl_word_t  ctl_o
);

    import tomasulo_issue_pkg::*;

    logic [`NUM_GEN_RS-1:0] gen_pick;
    logic                   gen_found;
    logic                   is_branch;
    logic                   can_issue;

    // lowest index free station wins
    always_comb begin
        gen_pick  = '0;
        gen_found = 1'b0;
        for (int k = 0; k < `NUM_GEN_RS; k++) begin
            if (status_i.rs_free[k] && !gen_found) begin
                gen_pick[k] = 1'b1;
                gen_found   = 1'b1;
            end
        end
    end

    assign is_branch = (head_i.op == BRANCH);

    // head valid with room in the rob and its station free
    always_comb begin
        can_issue = 1'b0;
        if (head_valid_i && !status_i.rob_full) begin
            can_issue = is_branch ? status_i.rsbr_free : gen_found;
        end
    end

    always_comb begin
        dispatch_o = '0;
        if (can_issue) begin
            dispatch_o.rob_load = 1'b1;
            if (is_branch) begin
                dispatch_o.rsbr_load = 1'b1;
            end else begin
                dispatch_o.rs_load = gen_pick;
            end
            // stores and branches get no tag
            dispatch_o.regfile_allocate = ~head_i.op[3];
        end
    end

    assign yumi_o = can_issue;
    assign ctl_o  = head_i;

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ns

module instr_decoder (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  tomasulo_issue_pkg::instr_fmt_u instr_i,
    input  logic [31:0]                    pc_i,
    input  logic                           instr_valid_i,
    output logic                           instr_ready_o,
    output logic                           ctl_valid_o,
    output tomasulo_issue_pkg::ctl_word_t  ctl_o,
    input  logic                           ctl_ready_i
);

    import tomasulo_issue_pkg::*;

    ctl_word_t ctl_d;
    ctl_word_t ctl_q;
    logic      supported_d;
    logic      ctl_valid_q;
    logic      accept;

    always_comb begin
        ctl_d       = '0;
        ctl_d.op    = ALU_R;
        ctl_d.pc    = pc_i;
        supported_d = 1'b1;

        case (instr_i.r_fmt.opcode)
            OPC_OP: begin
                ctl_d.op         = ALU_R;
                ctl_d.src1_reg   = instr_i.r_fmt.rs1;
                ctl_d.src1_valid = 1'b1;
                ctl_d.src2_reg   = instr_i.r_fmt.rs2;
                ctl_d.src2_valid = 1'b1;
                ctl_d.funct3     = instr_i.r_fmt.funct3;
                ctl_d.funct7_b5  = instr_i.r_fmt.funct7[5];
                ctl_d.rd         = instr_i.r_fmt.rd;
            end
            OPC_OP_IMM: begin
                ctl_d.op         = ALU_I;
                ctl_d.src1_reg   = instr_i.i_fmt.rs1;
                ctl_d.src1_valid = 1'b1;
                ctl_d.src2_data  = {{20{instr_i.i_fmt.imm_11_0[11]}},
                                    instr_i.i_fmt.imm_11_0};
                ctl_d.funct3     = instr_i.i_fmt.funct3;
                // srli vs srai, bit 30 of the word
                if (instr_i.i_fmt.funct3 == 3'b101) begin
                    ctl_d.funct7_b5 = instr_i.r_fmt.funct7[5];
                end
                ctl_d.rd         = instr_i.i_fmt.rd;
            end
            OPC_LOAD: begin
                ctl_d.op         = LOAD;
                ctl_d.src1_reg   = instr_i.i_fmt.rs1;
                ctl_d.src1_valid = 1'b1;
                ctl_d.src2_data  = {{20{instr_i.i_fmt.imm_11_0[11]}},
                                    instr_i.i_fmt.imm_11_0};
                ctl_d.funct3     = instr_i.i_fmt.funct3;
                ctl_d.rd         = instr_i.i_fmt.rd;
            end
            OPC_STORE: begin
                ctl_d.op         = STORE;
                ctl_d.src1_reg   = instr_i.s_fmt.rs1;
                ctl_d.src1_valid = 1'b1;
                ctl_d.src2_reg   = instr_i.s_fmt.rs2;
                ctl_d.src2_valid = 1'b1;
                ctl_d.src2_data  = {{20{instr_i.s_fmt.imm_11_5[6]}},
                                    instr_i.s_fmt.imm_11_5,
                                    instr_i.s_fmt.imm_4_0};
                ctl_d.funct3     = instr_i.s_fmt.funct3;
            end
            OPC_BRANCH: begin
                ctl_d.op         = BRANCH;
                ctl_d.src1_reg   = instr_i.b_fmt.rs1;
                ctl_d.src1_valid = 1'b1;
                ctl_d.src2_reg   = instr_i.b_fmt.rs2;
                ctl_d.src2_valid = 1'b1;
                // 13-bit offset, lsb always zero
                ctl_d.src2_data  = {{19{instr_i.b_fmt.imm_12}},
                                    instr_i.b_fmt.imm_12,
                                    instr_i.b_fmt.imm_11,
                                    instr_i.b_fmt.imm_10_5,
                                    instr_i.b_fmt.imm_4_1,
                                    1'b0};
                ctl_d.funct3     = instr_i.b_fmt.funct3;
            end
            default: begin
                // swallowed here, nothing goes downstream
                supported_d = 1'b0;
            end
        endcase
    end

    // register empty, or its word leaves this cycle
    assign instr_ready_o = ~ctl_valid_q | ctl_ready_i;
    assign accept        = instr_valid_i & instr_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctl_valid_q <= 1'b0;
        end else if (accept) begin
            ctl_valid_q <= supported_d;
        end else if (ctl_ready_i) begin
            ctl_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl_q <= ctl_d;
        end
    end

    assign ctl_valid_o = ctl_valid_q;
    assign ctl_o       = ctl_q;

endmodule

`default_nettype wire

// File: design/issue_queue.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_issue_cfg.svh"

module issue_queue (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  tomasulo_issue_pkg::ctl_word_t data_i,
    input  logic                          valid_i,
    output logic                          ready_o,
    output logic                          valid_o,
    output tomasulo_issue_pkg::ctl_word_t data_o,
    input  logic                          yumi_i
);

    import tomasulo_issue_pkg::*;

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    localparam logic [AW-1:0] LAST_PTR   = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

    ctl_word_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          enq;
    logic          deq;

    // full queue still takes a word when the head leaves
    assign ready_o = (count != FULL_COUNT) | yumi_i;
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    assign enq = valid_i & ready_o;
    assign deq = yumi_i & valid_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (enq && !deq) begin
                count <= count + 1'b1;
            end else if (deq && !enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_stage_top.sv
`default_nettype none
`timescale 1ns/1ns

module issue_stage_top (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  tomasulo_issue_pkg::instr_fmt_u instr_i,
    input  logic [31:0]                    pc_i,
    input  logic                           instr_valid_i,
    output logic                           instr_ready_o,
    input  tomasulo_issue_pkg::rs_status_t status_i,
    output tomasulo_issue_pkg::dispatch_t  dispatch_o,
    output tomasulo_issue_pkg::ctl_word_t  ctl_o
);

    import tomasulo_issue_pkg::*;

    logic      dec_valid;
    ctl_word_t dec_ctl;
    logic      q_ready;
    logic      head_valid;
    ctl_word_t head;
    logic      yumi;

    instr_decoder instr_decoder_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .ctl_valid_o   (dec_valid),
        .ctl_o         (dec_ctl),
        .ctl_ready_i   (q_ready)
    );

    issue_queue issue_queue_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (dec_ctl),
        .valid_i (dec_valid),
        .ready_o (q_ready),
        .valid_o (head_valid),
        .data_o  (head),
        .yumi_i  (yumi)
    );

    // head goes out as ctl_o, valid only with rob_load
    dispatch_ctrl dispatch_ctrl_i (
        .head_valid_i (head_valid),
        .head_i       (head),
        .status_i     (status_i),
        .yumi_o       (yumi),
        .dispatch_o   (dispatch_o),
        .ctl_o        (ctl_o)
    );

endmodule

`default_nettype wire

// File: design/tomasulo_issue_cfg.svh
`ifndef TOMASULO_ISSUE_CFG_SVH
`define TOMASULO_ISSUE_CFG_SVH

// entries in the issue queue
// any depth of 2 or more works, the pointers wrap explicitly
`define ISSUE_QUEUE_DEPTH 8

// general reservation stations, the branch station is extra
`define NUM_GEN_RS 4

`endif

// File: design/tomasulo_issue_pkg.sv
`default_nettype none

`include "tomasulo_issue_cfg.svh"

package tomasulo_issue_pkg;

    // rv32i major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // bit 3 marks the classes without a destination register
    typedef enum logic [3:0] {
        ALU_R  = 4'b0000,
        ALU_I  = 4'b0001,
        LOAD   = 4'b0010,
        STORE  = 4'b1000,
        BRANCH = 4'b1001
    } op_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // one instruction word, four ways to look at it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_fmt_u;

    typedef struct packed {
        op_class_e   op;
        logic [4:0]  src1_reg;
        logic        src1_valid;
        logic [4:0]  src2_reg;
        logic        src2_valid;
        logic [31:0] src2_data;
        logic [2:0]  funct3;
        logic        funct7_b5;
        logic [4:0]  rd;
        logic [31:0] pc;
    } ctl_word_t;

    typedef struct packed {
        logic [`NUM_GEN_RS-1:0] rs_free;
        logic                   rsbr_free;
        logic                   rob_full;
    } rs_status_t;

    typedef struct packed {
        logic                   rob_load;
        logic                   regfile_allocate;
        logic [`NUM_GEN_RS-1:0] rs_load;
        logic                   rsbr_load;
    } dispatch_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module issue_stage_tb -f tomasulo_issue.f -Mdir obj_dir

sim_out=$(./obj_dir/Vissue_stage_tb || true)
echo "$sim_out"

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: test/issue_stage_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_issue_cfg.svh"

module issue_stage_tb;

    import tomasulo_issue_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        drop;
        ctl_word_t   exp;
    } stim_entry_t;

    logic        clk;
    logic        rst_n_i;
    instr_fmt_u  instr_i;
    logic [31:0] pc_i;
    logic        instr_valid_i;
    logic        instr_ready_o;
    rs_status_t  status_i;
    dispatch_t   dispatch_o;
    ctl_word_t   ctl_o;

    stim_entry_t stim_tab [$];
    ctl_word_t   sb [$];
    logic [31:0] lfsr_state;
    logic [31:0] next_pc;
    int          block_mode;
    int          n_main;

    tb_clock_gen clock_gen_i (
        .clk_o (clk)
    );

    issue_stage_top issue_stage_top_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .status_i      (status_i),
        .dispatch_o    (dispatch_o),
        .ctl_o         (ctl_o)
    );

    task automatic stop_fail();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_ctl(input ctl_word_t got, input ctl_word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: ctl_o got %h expected %h", $time, got, exp);
            stop_fail();
        end
    endtask

    task automatic check_dispatch(input dispatch_t got, input dispatch_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: dispatch_o got %b expected %b (status %b)",
                     $time, got, exp, status_i);
            stop_fail();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: instr_ready_o got %b expected %b", $time, got, exp);
            stop_fail();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic drive_status();
        rs_status_t st;
        logic       b1;
        logic       b2;
        st = '0;
        for (int k = 0; k < `NUM_GEN_RS; k++) begin
            take_bit(b1);
            st.rs_free[k] = b1;
        end
        take_bit(b1);
        st.rsbr_free = b1;
        // rob full about a quarter of the time
        take_bit(b1);
        take_bit(b2);
        st.rob_full = b1 & b2;
        if (block_mode == 1) begin
            st.rob_full = 1'b1;
        end else if (block_mode == 2) begin
            st.rs_free   = '0;
            st.rsbr_free = 1'b0;
        end
        status_i = st;
    endtask

    // strobes the dispatch rules call for with the head's class
    function automatic dispatch_t expect_dispatch(input rs_status_t st, input op_class_e op);
        dispatch_t d;
        int        pick;
        d    = '0;
        pick = -1;
        for (int k = `NUM_GEN_RS - 1; k >= 0; k--) begin
            if (st.rs_free[k]) begin
                pick = k;
            end
        end
        if (!st.rob_full) begin
            if (op == BRANCH) begin
                d.rob_load  = st.rsbr_free;
                d.rsbr_load = st.rsbr_free;
            end else if (pick >= 0) begin
                d.rob_load      = 1'b1;
                d.rs_load[pick] = 1'b1;
            end
        end
        d.regfile_allocate = d.rob_load & (op == ALU_R || op == ALU_I || op == LOAD);
        return d;
    endfunction

    // encodes one instruction and its expected word from the same fields
    task automatic add_entry(input op_class_e op, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [12:0] imm,
                             input logic [2:0] f3, input logic f7b5);
        stim_entry_t e;
        e                = '0;
        e.pc             = next_pc;
        e.exp.op         = op;
        e.exp.pc         = next_pc;
        e.exp.src1_reg   = rs1;
        e.exp.src1_valid = 1'b1;
        e.exp.funct3     = f3;
        case (op)
            ALU_R: begin
                e.instr          = {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                e.exp.src2_reg   = rs2;
                e.exp.src2_valid = 1'b1;
                e.exp.funct7_b5  = f7b5;
                e.exp.rd         = rd;
            end
            ALU_I, LOAD: begin
                e.instr = {imm[11:0], rs1, f3, rd,
                           (op == LOAD) ? 7'b0000011 : 7'b0010011};
                e.exp.src2_data = {{20{imm[11]}}, imm[11:0]};
                e.exp.rd        = rd;
                // shift right immediate carries its arith bit in imm[10]
                if (op == ALU_I && f3 == 3'b101) begin
                    e.exp.funct7_b5 = imm[10];
                end
            end
            STORE: begin
                e.instr          = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
                e.exp.src2_reg   = rs2;
                e.exp.src2_valid = 1'b1;
                e.exp.src2_data  = {{20{imm[11]}}, imm[11:0]};
            end
            default: begin
                e.instr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
                e.exp.src2_reg   = rs2;
                e.exp.src2_valid = 1'b1;
                e.exp.src2_data  = {{19{imm[12]}}, imm[12:1], 1'b0};
            end
        endcase
        stim_tab.push_back(e);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic add_drop(input logic [31:0] instr);
        stim_entry_t e;
        e       = '0;
        e.instr = instr;
        e.pc    = next_pc;
        e.drop  = 1'b1;
        stim_tab.push_back(e);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic build_table();
        next_pc = 32'h0000_1000;
        add_entry(ALU_R,  5'd3,  5'd1,  5'd2,  13'h0000, 3'b000, 1'b0);
        add_entry(ALU_R,  5'd5,  5'd6,  5'd7,  13'h0000, 3'b000, 1'b1);
        add_entry(ALU_I,  5'd8,  5'd9,  5'd0,  13'h1ffb, 3'b000, 1'b0);
        add_entry(ALU_I,  5'd10, 5'd11, 5'd0,  13'h0405, 3'b101, 1'b0);
        add_entry(LOAD,   5'd12, 5'd13, 5'd0,  13'h07ff, 3'b010, 1'b0);
        add_entry(STORE,  5'd0,  5'd15, 5'd14, 13'h1ff0, 3'b010, 1'b0);
        add_entry(BRANCH, 5'd0,  5'd1,  5'd2,  13'h0800, 3'b000, 1'b0);
        add_drop(32'h1234_52b7);
        add_entry(BRANCH, 5'd0,  5'd3,  5'd4,  13'h1000, 3'b001, 1'b0);
        add_drop(32'h0080_006f);
        add_entry(ALU_R,  5'd20, 5'd21, 5'd22, 13'h0000, 3'b111, 1'b0);
        add_entry(BRANCH, 5'd0,  5'd5,  5'd6,  13'h000c, 3'b100, 1'b0);
        add_entry(LOAD,   5'd1,  5'd2,  5'd0,  13'h1fff, 3'b000, 1'b0);
        add_entry(STORE,  5'd0,  5'd4,  5'd3,  13'h0006, 3'b001, 1'b0);
        add_drop(32'h0ff0_000f);
        add_entry(ALU_I,  5'd7,  5'd8,  5'd0,  13'h0555, 3'b110, 1'b0);
        add_entry(ALU_I,  5'd9,  5'd9,  5'd0,  13'h0003, 3'b001, 1'b0);
        add_drop(32'h0000_0073);
        n_main = stim_tab.size();
        // fill burst of one more than the queue holds
        for (int k = 0; k <= `ISSUE_QUEUE_DEPTH; k++) begin
            if (k % 2 == 0) begin
                add_entry(ALU_I, 5'(k + 1), 5'(k), 5'd0, 13'(k * 8), 3'b000, 1'b0);
            end else begin
                add_entry(BRANCH, 5'd0, 5'(k), 5'(k + 2), 13'(k * 8), 3'b001, 1'b0);
            end
        end
    endtask

    // holds valid until the decoder takes the word and returns at posedge + 1
    task automatic send_entry(input stim_entry_t e);
        int   cyc;
        logic taken;
        cyc           = 0;
        taken         = 1'b0;
        instr_i       = e.instr;
        pc_i          = e.pc;
        instr_valid_i = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready_o;
            @(posedge clk);
            #1;
            cyc++;
            if (!taken && cyc > WAIT_LIMIT) begin
                $display("instruction at pc %h was never accepted", e.pc);
                stop_fail();
            end
        end
        instr_valid_i = 1'b0;
        if (!e.drop) begin
            sb.push_back(e.exp);
        end
    endtask

    task automatic wait_ready_low();
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                $display("instr_ready_o stayed high with dispatch blocked");
                stop_fail();
            end
        end while (instr_ready_o !== 1'b0);
    endtask

    task automatic wait_drained();
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                $display("%0d instructions were never dispatched", sb.size());
                stop_fail();
            end
        end while (sb.size() != 0);
    endtask

    task automatic check_cycle();
        ctl_word_t exp_ctl;
        if (!dispatch_o.rob_load) begin
            check_dispatch(dispatch_o, '0);
        end else if (sb.size() == 0) begin
            $display("dispatch at %0t ns with no instruction outstanding", $time);
            stop_fail();
        end else begin
            exp_ctl = sb.pop_front();
            check_dispatch(dispatch_o, expect_dispatch(status_i, exp_ctl.op));
            check_ctl(ctl_o, exp_ctl);
        end
    endtask

    // new status shortly after each rising edge
    always @(posedge clk) begin
        #1;
        drive_status();
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            check_cycle();
        end
    end

    initial begin
        instr_i       = '0;
        pc_i          = '0;
        instr_valid_i = 1'b0;
        status_i      = '0;
        rst_n_i       = 1'b0;
        block_mode    = 0;
        lfsr_state    = 32'h600f_a74c;
        build_table();

        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_dispatch(dispatch_o, '0);
        check_ready(instr_ready_o, 1'b1);

        @(posedge clk);
        #1;
        for (int i = 0; i < n_main; i++) begin
            send_entry(stim_tab[i]);
        end
        wait_drained();

        // mode 2 clears the free bits and mode 1 holds the rob full
        for (int mode = 2; mode >= 1; mode--) begin
            block_mode = mode;
            @(posedge clk);
            #1;
            for (int i = n_main; i < stim_tab.size(); i++) begin
                send_entry(stim_tab[i]);
            end
            wait_ready_low();
            block_mode = 0;
            wait_drained();
        end

        // quiet tail where any stray dispatch is caught
        repeat (20) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: tomasulo_issue.f
+incdir+design
design/tomasulo_issue_pkg.sv
design/instr_decoder.sv
design/issue_queue.sv
design/dispatch_ctrl.sv
design/issue_stage_top.sv
test/tb_clock_gen.sv
test/issue_stage_tb.sv
